/* sim.f */
rtl/packer_pkg.sv
rtl/stream_fifo.sv
rtl/body_buffer.sv
rtl/frame_assembler.sv
rtl/packer_control.sv
rtl/request_packer.sv
test/tb_request_packer.sv

/* Bender.yml */
package:
  name: request_packer

sources:
  - files:
      - rtl/packer_pkg.sv
      - rtl/stream_fifo.sv
      - rtl/body_buffer.sv
      - rtl/frame_assembler.sv
      - rtl/packer_control.sv
      - rtl/request_packer.sv
  - target: simulation
    files:
      - test/tb_request_packer.sv

/* test/packer_patterns.txt */
# name dest_mac src_mac dest_ip src_ip dest_port src_port transmission_id beats last_keep
#   stall packets (addresses, ports and ids in hex, the last four columns in decimal)
short_image   02aabbccdd01 02aabbccdd10 c0a80a02 c0a80a01 1f90 c350 00000101 3 20 0 1
long_image    02aabbccdd02 02aabbccdd10 c0a80a03 c0a80a01 1f91 c351 00000102 65 32 0 3
new_meta      02aabbccdd03 02aabbccdd11 c0a80a04 c0a80a05 1f92 c352 00000103 12 7 0 1
exact_chunk   02aabbccdd04 02aabbccdd11 c0a80a06 c0a80a05 1f93 c353 00000104 30 32 0 1
repeat_meta   02aabbccdd04 02aabbccdd11 c0a80a06 c0a80a05 1f93 c353 00000104 31 1 0 2
back_pressure 02aabbccdd05 02aabbccdd12 0a000002 0a000001 2710 4e20 00000105 40 13 1 2

/* test/tb_request_packer.sv */
/*
 * Testbench for the request packer. Each line of the pattern file describes
 * one image; its body comes from the LFSR, and every output beat is checked
 * against packets built from the chunking and header rules.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_request_packer import packer_pkg::*; ();

    localparam int WAIT_LIMIT   = 4000;
    localparam int QUIET_CYCLES = 16;

    logic        axis_aclk;
    logic        axis_resetn;
    pkt_meta_t   meta_in;
    axis_beat_t  in_beat;
    logic        in_valid;
    logic        in_ready;
    axis_beat_t  out_beat;
    logic        out_valid;
    logic        out_ready;

    axis_beat_t  in_q[$];
    axis_beat_t  exp_q[$];
    logic [31:0] lfsr_state;
    pkt_meta_t   model_meta;
    len_t        model_seq;
    len_t        model_pkt_id;
    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;
    bit          timed_out;

    request_packer uut (
        .axis_aclk   (axis_aclk),
        .axis_resetn (axis_resetn),
        .meta_in     (meta_in),
        .in_beat     (in_beat),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .out_beat    (out_beat),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

    initial begin
        axis_aclk = 1'b0;
        forever #50 axis_aclk = ~axis_aclk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [DATA_BYTES-1:0] low_keep(input int n);
        logic [DATA_BYTES-1:0] k;
        k = '0;
        for (int i = 0; i < n; i++) begin
            k[i] = 1'b1;
        end
        return k;
    endfunction

    function automatic int keep_bytes(input logic [DATA_BYTES-1:0] keep);
        int n;
        n = 0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            n += keep[i];
        end
        return n;
    endfunction

    // Big-endian field placed from wire byte off onwards
    function automatic logic [DATA_BYTES*8-1:0] put_field(input logic [DATA_BYTES*8-1:0] d,
            input int off, input int nbytes, input logic [63:0] val);
        for (int k = 0; k < nbytes; k++) begin
            d[8*(off+k) +: 8] = val[8*(nbytes-1-k) +: 8];
        end
        return d;
    endfunction

    function automatic axis_beat_t header_beat(input logic [DATA_BYTES*8-1:0] d, input int n);
        axis_beat_t b;
        b.data = d;
        b.keep = low_keep(n);
        b.last = 1'b0;
        return b;
    endfunction

    task automatic make_body(input int n, input int last_keep);
        axis_beat_t  b;
        logic [31:0] word;
        in_q.delete();
        for (int i = 0; i < n; i++) begin
            for (int w = 0; w < DATA_BYTES/4; w++) begin
                take_bits(32, word);
                b.data[32*w +: 32] = word;
            end
            b.keep = (i == n - 1) ? low_keep(last_keep) : '1;
            b.last = (i == n - 1);
            in_q.push_back(b);
        end
    endtask

    // Reference packets for the body now in in_q
    task automatic build_expected(input pkt_meta_t meta);
        logic [DATA_BYTES*8-1:0] d;
        axis_beat_t              b;
        int                      n;
        int                      start;
        int                      len;
        int                      bytes;
        bit                      img_last;
        n = in_q.size();
        start = 0;
        exp_q.delete();
        while (start < n) begin
            len = (n - start > CHUNK_BEATS) ? CHUNK_BEATS : n - start;
            img_last = (start + len == n);
            bytes = 0;
            for (int j = 0; j < len; j++) begin
                bytes += keep_bytes(in_q[start+j].keep);
            end
            model_seq = (meta == model_meta) ? model_seq + 1'b1 : len_t'(1);
            model_meta = meta;
            model_pkt_id = model_pkt_id + 1'b1;

            d = put_field('0, 0, 6, meta.dest_mac);
            d = put_field(d, 6, 6, meta.src_mac);
            d = put_field(d, 12, 2, ETHERTYPE_IPV4);
            exp_q.push_back(header_beat(d, ETH_HDR_BYTES));

            // Flags, fragment offset and checksum stay zero
            d = put_field('0, 0, 1, 8'h45);
            d = put_field(d, 2, 2, bytes + IP_HDR_BYTES + UDP_HDR_BYTES);
            d = put_field(d, 4, 2, model_pkt_id);
            d = put_field(d, 8, 1, IP_TTL);
            d = put_field(d, 9, 1, IP_PROTO_UDP);
            d = put_field(d, 12, 4, meta.src_ip);
            d = put_field(d, 16, 4, meta.dest_ip);
            exp_q.push_back(header_beat(d, IP_HDR_BYTES));

            d = put_field('0, 0, 2, meta.src_port);
            d = put_field(d, 2, 2, meta.dest_port);
            d = put_field(d, 4, 2, bytes + UDP_HDR_BYTES);
            exp_q.push_back(header_beat(d, UDP_HDR_BYTES));

            d = put_field('0, 0, 1, img_last);
            d = put_field(d, 2, 2, model_seq);
            d = put_field(d, 4, 4, meta.transmission_id);
            exp_q.push_back(header_beat(d, REQ_HDR_BYTES));

            for (int j = 0; j < len; j++) begin
                b = in_q[start+j];
                b.last = (j == len - 1);
                exp_q.push_back(b);
            end
            start += len;
        end
    endtask

    task automatic drive_image(input string name, input pkt_meta_t meta);
        int idx;
        int waited;
        idx = 0;
        waited = 0;
        while (idx < in_q.size() && !timed_out) begin
            @(negedge axis_aclk);
            meta_in = meta;
            in_beat = in_q[idx];
            in_valid = 1'b1;
            // in_ready only moves on the rising edge
            if (in_ready) begin
                idx++;
                waited = 0;
            end else begin
                waited++;
                if (waited >= WAIT_LIMIT) begin
                    $display("%s: in_ready stayed low for %0d cycles at input beat %0d",
                             name, WAIT_LIMIT, idx);
                    test_errors++;
                    timed_out = 1'b1;
                end
            end
        end
        @(negedge axis_aclk);
        in_valid = 1'b0;
        in_beat = '0;
    endtask

    task automatic collect_output(input string name, input bit stall, input int packets_expected);
        axis_beat_t  exp_beat;
        axis_beat_t  got_beat;
        logic [31:0] r;
        int          idx;
        int          waited;
        int          packets;
        bit          extra;
        idx = 0;
        waited = 0;
        packets = 0;
        extra = 1'b0;
        while (exp_q.size() > 0 && !timed_out) begin
            @(negedge axis_aclk);
            if (stall) begin
                // Ready on about one cycle in sixteen so the output queue fills up
                take_bits(4, r);
                out_ready = &r[3:0];
            end else begin
                out_ready = 1'b1;
            end
            if (out_valid && out_ready) begin
                got_beat = out_beat;
                exp_beat = exp_q.pop_front();
                if (got_beat !== exp_beat) begin
                    $display("Error %s: beat %0d expected %h, actual %h",
                             name, idx, exp_beat, got_beat);
                    test_errors++;
                end
                if (got_beat.last) begin
                    packets++;
                end
                idx++;
                waited = 0;
            end else begin
                waited++;
                if (waited >= WAIT_LIMIT) begin
                    $display("%s: no output beat for %0d cycles, %0d beats still expected",
                             name, WAIT_LIMIT, exp_q.size());
                    test_errors++;
                    timed_out = 1'b1;
                end
            end
        end
        if (!timed_out) begin
            if (packets != packets_expected) begin
                $display("Error %s: packet count expected %0d, actual %0d",
                         name, packets_expected, packets);
                test_errors++;
            end
            // Nothing may follow the predicted packets
            for (int i = 0; i < QUIET_CYCLES; i++) begin
                @(negedge axis_aclk);
                if (out_valid) begin
                    extra = 1'b1;
                end
            end
            if (extra) begin
                $display("%s: the DUT sent output beats beyond the expected packets", name);
                test_errors++;
            end
        end
    endtask

    task automatic finish_test(input string name);
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, test_errors);
        end
    endtask

    task automatic check_reset();
        tests_run++;
        test_errors = 0;
        if (out_valid !== 1'b0) begin
            $display("Error after_reset: out_valid expected 0, actual %b", out_valid);
            test_errors++;
        end
        if (in_ready !== 1'b0) begin
            $display("Error after_reset: in_ready expected 0, actual %b", in_ready);
            test_errors++;
        end
        finish_test("after_reset");
    endtask

    task automatic run_pattern(input string line);
        string       name;
        logic [47:0] dmac;
        logic [47:0] smac;
        logic [31:0] dip;
        logic [31:0] sip;
        logic [31:0] tid;
        logic [15:0] dport;
        logic [15:0] sport;
        int          beats;
        int          last_keep;
        int          stall;
        int          packets;
        int          fields;
        pkt_meta_t   meta;
        tests_run++;
        test_errors = 0;
        fields = $sscanf(line, "%s %h %h %h %h %h %h %h %d %d %d %d", name, dmac, smac,
                         dip, sip, dport, sport, tid, beats, last_keep, stall, packets);
        if (fields != 12) begin
            $display("A pattern line could not be read: %s", line);
            test_errors++;
            finish_test("bad_pattern");
        end else begin
            meta.dest_mac = dmac;
            meta.src_mac = smac;
            meta.dest_ip = dip;
            meta.src_ip = sip;
            meta.dest_port = dport;
            meta.src_port = sport;
            meta.transmission_id = tid;
            make_body(beats, last_keep);
            build_expected(meta);
            fork
                drive_image(name, meta);
                collect_output(name, stall != 0, packets);
            join
            finish_test(name);
        end
    endtask

    initial begin
        int    fd;
        string line;
        axis_resetn = 1'b0;
        meta_in = '0;
        in_beat = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        lfsr_state = 32'hafae_7678;
        model_meta = '0;
        model_seq = '0;
        model_pkt_id = '0;
        test_errors = 0;
        total_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        timed_out = 1'b0;

        repeat (2) @(posedge axis_aclk);
        @(negedge axis_aclk);
        axis_resetn = 1'b1;
        @(negedge axis_aclk);
        check_reset();

        fd = $fopen("test/packer_patterns.txt", "r");
        if (fd == 0) begin
            $display("The pattern file test/packer_patterns.txt could not be opened");
            total_errors++;
        end else begin
            while (!timed_out && !$feof(fd)) begin
                if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
                    run_pattern(line);
                end
            end
            $fclose(fd);
        end

        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/request_packer.sv */
/*
 * Top level of the inference request packer.
 * Image body beats come in on in_beat with meta_in held for the image, and
 * UDP/IPv4 request packets leave on out_beat, one per body chunk.
 */
`timescale 1ns/1ps
`default_nettype none

module request_packer import packer_pkg::*; (
    input  logic       axis_aclk,
    input  logic       axis_resetn,
    input  pkt_meta_t  meta_in,
    input  axis_beat_t in_beat,
    input  logic       in_valid,
    output logic       in_ready,
    output axis_beat_t out_beat,
    output logic       out_valid,
    input  logic       out_ready
);

    logic       capture;
    logic       accept_en;
    logic       emit;
    emit_sel_t  emit_sel;
    logic       body_pop;
    axis_beat_t body_head;
    logic       body_empty;
    logic       body_last;
    logic       chunk_done;
    len_t       chunk_len;
    logic       chunk_image_last;
    axis_beat_t wr_beat;
    logic       wr_en;
    logic       out_empty;
    logic       out_nearly_full;

    assign body_pop  = emit & (emit_sel == sel_body);
    assign out_valid = ~out_empty;

    packer_control control (
        .axis_aclk       (axis_aclk),
        .axis_resetn     (axis_resetn),
        .in_valid        (in_valid),
        .chunk_done      (chunk_done),
        .body_empty      (body_empty),
        .body_last       (body_last),
        .out_nearly_full (out_nearly_full),
        .capture         (capture),
        .accept_en       (accept_en),
        .emit            (emit),
        .emit_sel        (emit_sel)
    );

    body_buffer body (
        .axis_aclk        (axis_aclk),
        .axis_resetn      (axis_resetn),
        .in_beat          (in_beat),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .accept_en        (accept_en),
        .pop              (body_pop),
        .head_beat        (body_head),
        .empty            (body_empty),
        .chunk_done       (chunk_done),
        .chunk_len        (chunk_len),
        .chunk_image_last (chunk_image_last)
    );

    frame_assembler assembler (
        .axis_aclk        (axis_aclk),
        .axis_resetn      (axis_resetn),
        .meta_in          (meta_in),
        .capture          (capture),
        .emit             (emit),
        .emit_sel         (emit_sel),
        .chunk_len        (chunk_len),
        .chunk_image_last (chunk_image_last),
        .body_beat        (body_head),
        .body_last        (body_last),
        .wr_beat          (wr_beat),
        .wr_en            (wr_en)
    );

    // Packets wait here until the downstream side takes them
    stream_fifo out_queue (
        .axis_aclk   (axis_aclk),
        .axis_resetn (axis_resetn),
        .wr_en       (wr_en),
        .wr_beat     (wr_beat),
        .rd_en       (out_ready & out_valid),
        .rd_beat     (out_beat),
        .empty       (out_empty),
        .nearly_full (out_nearly_full)
    );

endmodule

`default_nettype wire

/* rtl/packer_control.sv */
/*
 * Packer FSM. Starts an image chunk when body data shows up, reads it into the
 * body queue, then emits the four header beats and the chunk's body beats,
 * stalling whenever the output queue is nearly full.
 */
`timescale 1ns/1ps
`default_nettype none

module packer_control import packer_pkg::*; (
    input  logic      axis_aclk,
    input  logic      axis_resetn,
    input  logic      in_valid,
    input  logic      chunk_done,
    input  logic      body_empty,
    input  logic      body_last,
    input  logic      out_nearly_full,
    output logic      capture,
    output logic      accept_en,
    output logic      emit,
    output emit_sel_t emit_sel
);

    packer_state_t state;
    packer_state_t state_next;
    logic          room;

    assign room = ~out_nearly_full;

    always_comb begin
        state_next = state;
        capture    = 1'b0;
        accept_en  = 1'b0;
        emit       = 1'b0;
        emit_sel   = sel_body;

        case (state)
            idle: begin
                capture = in_valid;
                if (in_valid) begin
                    state_next = reading;
                end
            end
            reading: begin
                accept_en = 1'b1;
                if (chunk_done) begin
                    state_next = emit_eth;
                end
            end
            emit_eth: begin
                emit     = room;
                emit_sel = sel_eth;
                if (room) begin
                    state_next = emit_ip;
                end
            end
            emit_ip: begin
                emit     = room;
                emit_sel = sel_ip;
                if (room) begin
                    state_next = emit_udp;
                end
            end
            emit_udp: begin
                emit     = room;
                emit_sel = sel_udp;
                if (room) begin
                    state_next = emit_req;
                end
            end
            emit_req: begin
                emit     = room;
                emit_sel = sel_req;
                if (room) begin
                    state_next = emit_body;
                end
            end
            emit_body: begin
                emit = room & ~body_empty;
                // Chunk ends with the beat carrying the chunk-last bit
                if (emit && body_last) begin
                    state_next = idle;
                end
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge axis_aclk) begin
        if (!axis_resetn) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

/* rtl/frame_assembler.sv */
/*
 * Holds the per-image metadata and the sequence and packet counters, and builds
 * the Ethernet, IPv4, UDP and request header beats. Each emit registers one beat
 * for the output queue, taken from a header or from the body queue head.
 */
`timescale 1ns/1ps
`default_nettype none

module frame_assembler import packer_pkg::*; (
    input  logic       axis_aclk,
    input  logic       axis_resetn,
    input  pkt_meta_t  meta_in,
    input  logic       capture,
    input  logic       emit,
    input  emit_sel_t  emit_sel,
    input  len_t       chunk_len,
    input  logic       chunk_image_last,
    input  axis_beat_t body_beat,
    output logic       body_last,
    output axis_beat_t wr_beat,
    output logic       wr_en
);

    pkt_meta_t meta;
    len_t      seq_num;
    len_t      pkt_id;

    // Header images with the first wire byte in the top bits
    logic [DATA_BYTES*8-1:0] eth_be;
    logic [DATA_BYTES*8-1:0] ip_be;
    logic [DATA_BYTES*8-1:0] udp_be;
    logic [DATA_BYTES*8-1:0] req_be;

    // Byte 0 of the bus goes first on the wire
    function automatic logic [DATA_BYTES*8-1:0] wire_order(input logic [DATA_BYTES*8-1:0] be);
        logic [DATA_BYTES*8-1:0] le;
        for (int i = 0; i < DATA_BYTES; i++) begin
            le[8*i +: 8] = be[8*(DATA_BYTES-1-i) +: 8];
        end
        return le;
    endfunction

    function automatic logic [DATA_BYTES-1:0] low_keep(input int n);
        return DATA_BYTES'((64'd1 << n) - 64'd1);
    endfunction

    assign eth_be = {meta.dest_mac, meta.src_mac, ETHERTYPE_IPV4,
                     {(DATA_BYTES - ETH_HDR_BYTES)*8{1'b0}}};
    assign ip_be  = {8'h45, 8'h00, len_t'(chunk_len + IP_HDR_BYTES + UDP_HDR_BYTES), pkt_id,
                     16'h0000, IP_TTL, IP_PROTO_UDP, 16'h0000, meta.src_ip, meta.dest_ip,
                     {(DATA_BYTES - IP_HDR_BYTES)*8{1'b0}}};
    assign udp_be = {meta.src_port, meta.dest_port, len_t'(chunk_len + UDP_HDR_BYTES), 16'h0000,
                     {(DATA_BYTES - UDP_HDR_BYTES)*8{1'b0}}};
    assign req_be = {7'd0, chunk_image_last, 8'h00, seq_num, meta.transmission_id,
                     {(DATA_BYTES - REQ_HDR_BYTES)*8{1'b0}}};

    assign body_last = body_beat.last;

    // Metadata and counters
    always_ff @(posedge axis_aclk) begin
        if (!axis_resetn) begin
            meta    <= '0;
            seq_num <= '0;
            pkt_id  <= '0;
        end else if (capture) begin
            meta    <= meta_in;
            seq_num <= (meta_in == meta) ? seq_num + 1'b1 : len_t'(1);
            pkt_id  <= pkt_id + 1'b1;
        end
    end

    always_ff @(posedge axis_aclk) begin
        if (!axis_resetn) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= emit;
        end
    end

    always_ff @(posedge axis_aclk) begin
        if (emit) begin
            case (emit_sel)
                sel_eth:  wr_beat <= '{wire_order(eth_be), low_keep(ETH_HDR_BYTES), 1'b0};
                sel_ip:   wr_beat <= '{wire_order(ip_be), low_keep(IP_HDR_BYTES), 1'b0};
                sel_udp:  wr_beat <= '{wire_order(udp_be), low_keep(UDP_HDR_BYTES), 1'b0};
                sel_req:  wr_beat <= '{wire_order(req_be), low_keep(REQ_HDR_BYTES), 1'b0};
                default:  wr_beat <= body_beat;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/body_buffer.sv */
/*
 * Input queue for image body beats.
 * Cuts the body into chunks of at most CHUNK_BEATS beats, marking the chunk end
 * in the queued last bit, and counts the chunk's byte length from tkeep.
 */
`timescale 1ns/1ps
`default_nettype none

module body_buffer import packer_pkg::*; (
    input  logic       axis_aclk,
    input  logic       axis_resetn,
    input  axis_beat_t in_beat,
    input  logic       in_valid,
    output logic       in_ready,
    input  logic       accept_en,
    input  logic       pop,
    output axis_beat_t head_beat,
    output logic       empty,
    output logic       chunk_done,
    output len_t       chunk_len,
    output logic       chunk_image_last
);

    axis_beat_t queued_beat;
    logic       queue_nearly_full;
    logic       wr;
    logic       fresh;
    logic       chunk_last;
    len_t       beat_cnt;
    len_t       base_cnt;
    len_t       base_len;

    function automatic len_t keep_count(input logic [DATA_BYTES-1:0] keep);
        len_t n;
        n = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            n = n + len_t'(keep[i]);
        end
        return n;
    endfunction

    assign in_ready = accept_en & ~queue_nearly_full;
    assign wr       = in_valid & in_ready;

    // Finished totals stay visible until the next chunk starts
    assign base_cnt = fresh ? '0 : beat_cnt;
    assign base_len = fresh ? '0 : chunk_len;

    assign chunk_last  = in_beat.last | (base_cnt == len_t'(CHUNK_BEATS - 1));
    assign chunk_done  = wr & chunk_last;
    assign queued_beat = '{data: in_beat.data, keep: in_beat.keep, last: chunk_last};

    always_ff @(posedge axis_aclk) begin
        if (!axis_resetn) begin
            fresh            <= 1'b1;
            beat_cnt         <= '0;
            chunk_len        <= '0;
            chunk_image_last <= 1'b0;
        end else if (wr) begin
            fresh            <= chunk_last;
            beat_cnt         <= base_cnt + 1'b1;
            chunk_len        <= base_len + keep_count(in_beat.keep);
            chunk_image_last <= in_beat.last;
        end
    end

    stream_fifo body_queue (
        .axis_aclk   (axis_aclk),
        .axis_resetn (axis_resetn),
        .wr_en       (wr),
        .wr_beat     (queued_beat),
        .rd_en       (pop),
        .rd_beat     (head_beat),
        .empty       (empty),
        .nearly_full (queue_nearly_full)
    );

endmodule

`default_nettype wire

/* rtl/stream_fifo.sv */
/*
 * First-word-fall-through queue of stream beats.
 * The head entry is always on rd_beat; rd_en drops it.
 * nearly_full leaves NEARLY_FULL_MARGIN entries for writes already in flight.
 */
`timescale 1ns/1ps
`default_nettype none

module stream_fifo import packer_pkg::*; (
    input  logic       axis_aclk,
    input  logic       axis_resetn,
    input  logic       wr_en,
    input  axis_beat_t wr_beat,
    input  logic       rd_en,
    output axis_beat_t rd_beat,
    output logic       empty,
    output logic       nearly_full
);

    axis_beat_t mem [QUEUE_DEPTH];

    // Depth is a power of two, so pointers wrap on their own
    logic [$clog2(QUEUE_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(QUEUE_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(QUEUE_DEPTH+1)-1:0] count;
    logic                             do_wr;
    logic                             do_rd;

    assign empty       = (count == '0);
    assign nearly_full = (count >= QUEUE_DEPTH - NEARLY_FULL_MARGIN);
    assign do_wr       = wr_en & (count != QUEUE_DEPTH);
    assign do_rd       = rd_en & ~empty;
    assign rd_beat     = mem[rd_ptr];

    always_ff @(posedge axis_aclk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    always_ff @(posedge axis_aclk) begin
        if (!axis_resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/packer_pkg.sv */
/*
 * Shared widths, protocol constants and types for the inference request packer.
 * Every module that needs them imports this package with a wildcard import.
 */
`default_nettype none

package packer_pkg;

    localparam int DATA_BYTES         = 32;
    localparam int CHUNK_BEATS        = 30;
    localparam int QUEUE_DEPTH        = 32;
    localparam int NEARLY_FULL_MARGIN = 2;

    // Fixed header fields
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_TTL         = 8'd64;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;

    localparam int ETH_HDR_BYTES = 14;
    localparam int IP_HDR_BYTES  = 20;
    localparam int UDP_HDR_BYTES = 8;
    localparam int REQ_HDR_BYTES = 8;

    typedef logic [15:0] len_t;

    typedef struct packed {
        logic [DATA_BYTES*8-1:0] data;
        logic [DATA_BYTES-1:0]   keep;
        logic                    last;
    } axis_beat_t;

    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [31:0] dest_ip;
        logic [31:0] src_ip;
        logic [15:0] dest_port;
        logic [15:0] src_port;
        logic [31:0] transmission_id;
    } pkt_meta_t;

    typedef enum logic [2:0] {
        idle, reading, emit_eth, emit_ip, emit_udp, emit_req, emit_body
    } packer_state_t;

    // Output source of the assembler
    typedef enum logic [2:0] {
        sel_eth, sel_ip, sel_udp, sel_req, sel_body
    } emit_sel_t;

endpackage

`default_nettype wire
